// ==== source/muldiv_pkg.sv ====
/*
 * muldiv shared definitions
 * operand width, divider step count, opcodes and the
 * request, operand and result structs of the multiply-divide unit
 */
package muldiv_pkg;

   localparam int data_w    = 32;      // one machine word
   localparam int div_steps = data_w;  // one quotient bit per step

   // MIPS multiply-divide opcodes
   typedef enum logic [1:0] {
      OP_MULT  = 2'b00,
      OP_MULTU = 2'b01,
      OP_DIV   = 2'b10,
      OP_DIVU  = 2'b11
   } muldiv_op_e;

   // top-level request
   typedef struct packed {
      muldiv_op_e          op;
      logic [data_w-1:0]   a;
      logic [data_w-1:0]   b;
   } muldiv_req_t;

   // operands as seen by either arithmetic unit
   typedef struct packed {
      logic [data_w-1:0]   a;
      logic [data_w-1:0]   b;
      logic                is_signed;
   } operand_t;

   // product words, or remainder in hi and quotient in lo
   typedef struct packed {
      logic [data_w-1:0]   hi;
      logic [data_w-1:0]   lo;
   } hilo_t;

endpackage

// ==== source/mul_unit.sv ====
/*
 * pipelined multiplier
 * two-stage 33x33 signed multiply covering MULT and MULTU,
 * whole pipeline stalls while the result is not taken
 */
`timescale 1ns/100ps

module mul_unit (
   input  logic               aclk,
   input  logic               rst,
   input  logic               flush,
   input  logic               in_valid,
   output logic               in_ready,
   input  muldiv_pkg::operand_t in_data,
   output logic               out_valid,
   input  logic               out_ready,
   output muldiv_pkg::hilo_t  out_data
);
   import muldiv_pkg::*;

   logic                      advance;   // both stages move together
   logic                      s1_valid;
   logic                      s2_valid;
   logic signed [data_w:0]    a_ext;     // 33-bit extended operands
   logic signed [data_w:0]    b_ext;
   logic signed [2*data_w+1:0] prod;

   assign advance  = !s2_valid || out_ready;
   assign in_ready = advance;

   // valid bits
   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else if (flush) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else if (advance) begin
         s1_valid <= in_valid;
         s2_valid <= s1_valid;
      end
   end

   // stage 1: sign or zero extension
   always_ff @(posedge aclk) begin
      if (advance && in_valid) begin
         a_ext <= {in_data.is_signed & in_data.a[data_w-1], in_data.a};
         b_ext <= {in_data.is_signed & in_data.b[data_w-1], in_data.b};
      end
   end

   // stage 2: the product itself
   always_ff @(posedge aclk) begin
      if (advance && s1_valid) begin
         prod <= a_ext * b_ext;
      end
   end

   assign out_valid   = s2_valid;
   assign out_data.hi = prod[2*data_w-1:data_w];  // top two bits are sign copies
   assign out_data.lo = prod[data_w-1:0];

endmodule

// ==== source/div_unit.sv ====
/*
 * iterative divider
 * radix-2 restoring division on operand magnitudes,
 * signs fixed up after the last step; quotient to lo, remainder to hi
 */
`timescale 1ns/100ps

module div_unit (
   input  logic               aclk,
   input  logic               rst,
   input  logic               flush,
   input  logic               in_valid,
   output logic               in_ready,
   input  muldiv_pkg::operand_t in_data,
   output logic               out_valid,
   input  logic               out_ready,
   output muldiv_pkg::hilo_t  out_data
);
   import muldiv_pkg::*;

   typedef enum logic [1:0] {
      div_idle = 2'b00,
      div_run  = 2'b01,
      div_fix  = 2'b10,
      div_done = 2'b11
   } div_state_e;

   div_state_e                      state;
   logic [$clog2(div_steps)-1:0]    step_cnt;
   logic                            last_step;

   logic [data_w-1:0]   quo;       // dividend shifts out, quotient shifts in
   logic [data_w-1:0]   rem;
   logic [data_w-1:0]   dvs;       // divisor magnitude
   logic                q_neg;
   logic                r_neg;

   logic [data_w-1:0]   a_mag;
   logic [data_w-1:0]   b_mag;
   logic [data_w:0]     rem_sh;    // partial remainder with next dividend bit
   logic [data_w+1:0]   diff;      // trial subtraction, msb is the borrow

   // operand magnitudes at the input
   always_comb begin
      a_mag = in_data.a;
      b_mag = in_data.b;
      if (in_data.is_signed && in_data.a[data_w-1]) begin
         a_mag = -in_data.a;
      end
      if (in_data.is_signed && in_data.b[data_w-1]) begin
         b_mag = -in_data.b;
      end
   end

   assign rem_sh    = {rem, quo[data_w-1]};
   assign diff      = {1'b0, rem_sh} - {2'b00, dvs};
   assign last_step = (step_cnt == ($bits(step_cnt))'(div_steps - 1));

   // FSM
   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         state    <= div_idle;
         step_cnt <= '0;
      end else if (flush) begin
         state    <= div_idle;   // cancel whatever is running
         step_cnt <= '0;
      end else begin
         case (state)
            div_idle: begin
               if (in_valid) begin
                  state    <= div_run;
                  step_cnt <= '0;
               end
            end
            div_run: begin
               step_cnt <= step_cnt + 1'b1;
               if (last_step) begin
                  state <= div_fix;
               end
            end
            div_fix: begin
               state <= div_done;
            end
            div_done: begin
               if (out_ready) begin
                  state <= div_idle;
               end
            end
            default: state <= div_idle;
         endcase
      end
   end

   // datapath
   always_ff @(posedge aclk) begin
      case (state)
         div_idle: begin
            if (in_valid) begin
               quo   <= a_mag;
               dvs   <= b_mag;
               rem   <= '0;
               q_neg <= in_data.is_signed & (in_data.a[data_w-1] ^ in_data.b[data_w-1]);
               r_neg <= in_data.is_signed & in_data.a[data_w-1];  // remainder follows dividend
            end
         end
         div_run: begin
            if (!diff[data_w+1]) begin
               rem <= diff[data_w-1:0];         // subtract fits, quotient bit 1
               quo <= {quo[data_w-2:0], 1'b1};
            end else begin
               rem <= rem_sh[data_w-1:0];       // restore
               quo <= {quo[data_w-2:0], 1'b0};
            end
         end
         div_fix: begin
            if (q_neg) begin
               quo <= -quo;
            end
            if (r_neg) begin
               rem <= -rem;
            end
         end
         default: ;  // hold result in done
      endcase
   end

   assign in_ready    = (state == div_idle);
   assign out_valid   = (state == div_done);
   assign out_data.hi = rem;
   assign out_data.lo = quo;

endmodule

// ==== source/muldiv_seq.sv ====
/*
 * multiply-divide sequencer
 * decodes requests, issues them to one unit class at a time
 * and returns results in order through a response register
 */
`timescale 1ns/100ps

module muldiv_seq (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    flush,
   input  logic                    req_valid,
   output logic                    req_ready,
   input  muldiv_pkg::muldiv_req_t req,
   output logic                    mul_in_valid,
   input  logic                    mul_in_ready,
   output muldiv_pkg::operand_t    mul_in,
   input  logic                    mul_out_valid,
   output logic                    mul_out_ready,
   input  muldiv_pkg::hilo_t       mul_out,
   output logic                    div_in_valid,
   input  logic                    div_in_ready,
   output muldiv_pkg::operand_t    div_in,
   input  logic                    div_out_valid,
   output logic                    div_out_ready,
   input  muldiv_pkg::hilo_t       div_out,
   output logic                    rsp_valid,
   input  logic                    rsp_ready,
   output muldiv_pkg::hilo_t       rsp
);
   import muldiv_pkg::*;

   logic          run_en;      // low until the first edge after reset
   logic [1:0]    inflight;    // issued and not yet delivered
   logic          fl_div;      // class of what is in flight
   logic          req_is_div;
   logic          class_ok;
   logic          issue_ok;
   operand_t      opnd;
   logic          rsp_take;
   logic          rsp_load;

   assign req_is_div     = (req.op == OP_DIV) || (req.op == OP_DIVU);
   assign opnd.a         = req.a;
   assign opnd.b         = req.b;
   assign opnd.is_signed = (req.op == OP_MULT) || (req.op == OP_DIV);

   // a divide needs an empty machine, multiplies may queue behind multiplies
   assign class_ok = req_is_div ? (inflight == 2'd0) : (inflight == 2'd0 || !fl_div);
   assign issue_ok = run_en && !flush && class_ok;

   assign mul_in       = opnd;
   assign div_in       = opnd;
   assign mul_in_valid = req_valid && issue_ok && !req_is_div;
   assign div_in_valid = req_valid && issue_ok && req_is_div;
   assign req_ready    = issue_ok && (req_is_div ? div_in_ready : mul_in_ready);

   assign rsp_take      = !rsp_valid || rsp_ready;
   assign mul_out_ready = rsp_take;
   assign div_out_ready = rsp_take;
   assign rsp_load      = (mul_out_valid || div_out_valid) && rsp_take;

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         run_en    <= 1'b0;
         inflight  <= 2'd0;
         fl_div    <= 1'b0;
         rsp_valid <= 1'b0;
      end else if (flush) begin
         run_en    <= 1'b1;
         inflight  <= 2'd0;
         rsp_valid <= 1'b0;   // withdraw a presented response too
      end else begin
         run_en    <= 1'b1;
         inflight  <= inflight + 2'(req_valid && req_ready) - 2'(rsp_valid && rsp_ready);
         rsp_valid <= rsp_load || !rsp_take;
         if (req_valid && req_ready) begin
            fl_div <= req_is_div;
         end
      end
   end

   // response payload, at most one unit valid at a time
   always_ff @(posedge aclk) begin
      if (rsp_load) begin
         rsp <= mul_out_valid ? mul_out : div_out;
      end
   end

endmodule

// ==== source/muldiv_top.sv ====
/*
 * multiply-divide unit top
 * sequencer with the pipelined multiplier and iterative divider
 */
`timescale 1ns/100ps

module muldiv_top (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    flush,
   input  logic                    req_valid,
   output logic                    req_ready,
   input  muldiv_pkg::muldiv_req_t req,
   output logic                    rsp_valid,
   input  logic                    rsp_ready,
   output muldiv_pkg::hilo_t       rsp
);
   import muldiv_pkg::*;

   logic       mul_in_valid, mul_in_ready;
   operand_t   mul_in;
   logic       mul_out_valid, mul_out_ready;
   hilo_t      mul_out;
   logic       div_in_valid, div_in_ready;
   operand_t   div_in;
   logic       div_out_valid, div_out_ready;
   hilo_t      div_out;

   muldiv_seq u_seq (
      .aclk          (aclk),
      .rst           (rst),
      .flush         (flush),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .req           (req),
      .mul_in_valid  (mul_in_valid),
      .mul_in_ready  (mul_in_ready),
      .mul_in        (mul_in),
      .mul_out_valid (mul_out_valid),
      .mul_out_ready (mul_out_ready),
      .mul_out       (mul_out),
      .div_in_valid  (div_in_valid),
      .div_in_ready  (div_in_ready),
      .div_in        (div_in),
      .div_out_valid (div_out_valid),
      .div_out_ready (div_out_ready),
      .div_out       (div_out),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp           (rsp)
   );

   mul_unit u_mul (
      .aclk      (aclk),
      .rst       (rst),
      .flush     (flush),
      .in_valid  (mul_in_valid),
      .in_ready  (mul_in_ready),
      .in_data   (mul_in),
      .out_valid (mul_out_valid),
      .out_ready (mul_out_ready),
      .out_data  (mul_out)
   );

   div_unit u_div (
      .aclk      (aclk),
      .rst       (rst),
      .flush     (flush),
      .in_valid  (div_in_valid),
      .in_ready  (div_in_ready),
      .in_data   (div_in),
      .out_valid (div_out_valid),
      .out_ready (div_out_ready),
      .out_data  (div_out)
   );

endmodule

// ==== verif/muldiv_assert.sv ====
/*
 * sequencer protocol checks
 * response hold under back-pressure, one unit result at a time,
 * class-exclusive issue and a quiet response after reset
 */
`timescale 1ns/100ps

module muldiv_assert (
   input logic              aclk,
   input logic              rst,
   input logic              flush,
   input logic              mul_in_valid,
   input logic              mul_in_ready,
   input logic              div_in_valid,
   input logic              div_in_ready,
   input logic              mul_out_valid,
   input logic              div_out_valid,
   input logic              rsp_valid,
   input logic              rsp_ready,
   input muldiv_pkg::hilo_t rsp
);

   int         fail_cnt = 0;   // read by the testbench at the end
   logic       mul_xfer;
   logic       div_xfer;
   logic [2:0] pending;        // unit transfers not yet answered
   logic       pend_div;       // class of the last unit transfer

   assign mul_xfer = mul_in_valid && mul_in_ready;
   assign div_xfer = div_in_valid && div_in_ready;

   // shadow count built from the handshakes alone
   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         pending  <= '0;
         pend_div <= 1'b0;
      end else if (flush) begin
         pending  <= '0;
      end else begin
         pending <= pending + 3'(mul_xfer || div_xfer) - 3'(rsp_valid && rsp_ready);
         if (mul_xfer || div_xfer) begin
            pend_div <= div_xfer;
         end
      end
   end

   rsp_hold: assert property (@(posedge aclk) disable iff (!rst)
      rsp_valid && !rsp_ready && !flush |=> rsp_valid && $stable(rsp))
      else begin
         $error("rsp changed or dropped while rsp_ready was low");
         fail_cnt++;
      end

   one_result: assert property (@(posedge aclk) disable iff (!rst)
      !(mul_out_valid && div_out_valid))
      else begin
         $error("both units present a result");
         fail_cnt++;
      end

   mul_issue: assert property (@(posedge aclk) disable iff (!rst)
      mul_xfer |-> pending == 3'd0 || !pend_div)
      else begin
         $error("multiply issued with a divide in flight");
         fail_cnt++;
      end

   div_issue: assert property (@(posedge aclk) disable iff (!rst)
      div_xfer |-> pending == 3'd0 || pend_div)
      else begin
         $error("divide issued with a multiply in flight");
         fail_cnt++;
      end

   rst_quiet: assert property (@(posedge aclk) $rose(rst) |=> !rsp_valid)
      else begin
         $error("rsp_valid high right after reset");
         fail_cnt++;
      end

endmodule

// ==== verif/muldiv_tb.sv ====
/*
 * multiply-divide unit testbench
 * directed and random requests, back-pressure, latency and flush,
 * every response checked in order against a reference model
 */
`timescale 1ns/100ps

module muldiv_tb;
   import muldiv_pkg::*;

   localparam int clk_period = 8;
   localparam int n_random   = 200;
   localparam int n_directed = 40;   // upper bound on the directed requests

   logic          aclk = 1'b0;
   logic          rst;
   logic          flush;
   logic          req_valid;
   logic          req_ready;
   muldiv_req_t   req;
   logic          rsp_valid;
   logic          rsp_ready;
   hilo_t         rsp;

   int            seed = 87027;
   int            cyc = 0;           // rising edges so far
   int            errors = 0;
   int            checks = 0;
   int            test_errs = 0;
   int            n_sent = 0;
   int            n_rcvd = 0;
   int            n_cancel = 0;
   logic          rnd_ready = 1'b0;  // rsp_ready follows rdy_pat when set
   logic          rdy_pat [1024];
   hilo_t         exp_q [$];         // expected responses in request order

   logic [data_w-1:0] mul_a [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
   logic [data_w-1:0] mul_b [5] = '{32'h1234_5678, 32'hdead_beef, 32'hffff_ffff,
                                    32'h8000_0000, 32'hffff_ffff};
   logic [data_w-1:0] div_a [8] = '{32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'd100,
                                    32'h8000_0000, 32'd5, 32'hffff_fffb, 32'd0};
   logic [data_w-1:0] div_b [8] = '{32'hffff_fffe, 32'd2, 32'hffff_fffe, 32'd7,
                                    32'hffff_ffff, 32'd0, 32'd0, 32'd0};

   muldiv_top u_dut (
      .aclk      (aclk),
      .rst       (rst),
      .flush     (flush),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp)
   );

   bind muldiv_seq muldiv_assert u_assert (
      .aclk          (aclk),
      .rst           (rst),
      .flush         (flush),
      .mul_in_valid  (mul_in_valid),
      .mul_in_ready  (mul_in_ready),
      .div_in_valid  (div_in_valid),
      .div_in_ready  (div_in_ready),
      .mul_out_valid (mul_out_valid),
      .div_out_valid (div_out_valid),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp           (rsp)
   );

   always #(clk_period / 2) aclk = ~aclk;

   always @(posedge aclk) cyc <= cyc + 1;

   // reference model: product words, or remainder in hi and quotient in lo
   function automatic hilo_t expected_hilo(input muldiv_op_e op,
                                           input logic [data_w-1:0] a,
                                           input logic [data_w-1:0] b);
      hilo_t             res;
      logic [data_w-1:0] ma;
      logic [data_w-1:0] mb;
      logic [data_w-1:0] q;
      logic [data_w-1:0] r;
      logic              sgn;
      sgn = (op == OP_MULT) || (op == OP_DIV);
      if (op == OP_MULT) begin
         res = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      end else if (op == OP_MULTU) begin
         res = {32'b0, a} * {32'b0, b};
      end else begin
         ma = (sgn && a[31]) ? -a : a;
         mb = (sgn && b[31]) ? -b : b;
         if (mb == '0) begin
            q = '1;                     // restoring divide by zero
            r = ma;
         end else begin
            q = ma / mb;
            r = ma % mb;
         end
         if (sgn && (a[31] ^ b[31])) begin
            q = -q;
         end
         if (sgn && a[31]) begin
            r = -r;                     // remainder takes the dividend sign
         end
         res.hi = r;
         res.lo = q;
      end
      return res;
   endfunction

   task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic step();
      @(posedge aclk);
      #1;
   endtask

   // hold the request until it is taken, then log its expected result
   task automatic send_req(input muldiv_op_e op, input logic [data_w-1:0] a,
                           input logic [data_w-1:0] b, output int issue_cyc);
      req_valid = 1'b1;
      req.op    = op;
      req.a     = a;
      req.b     = b;
      @(negedge aclk);
      while (!req_ready) @(negedge aclk);
      exp_q.push_back(expected_hilo(op, a, b));
      issue_cyc = cyc;
      n_sent++;
      step();
      req_valid = 1'b0;
   endtask

   task automatic wait_rsp(output int at_cyc);
      int guard;
      guard  = 0;
      at_cyc = -1;
      while (at_cyc < 0 && guard < 100) begin
         @(negedge aclk);
         if (rsp_valid) begin
            at_cyc = cyc;
         end
         guard++;
      end
      if (at_cyc < 0) begin
         errors++;
         $display("ERROR: no response within 100 cycles, at %0t ns", $time);
      end
   endtask

   task automatic drain();
      while (exp_q.size() != 0) @(negedge aclk);
      step();
   endtask

   task automatic cancel_all();
      flush = 1'b1;
      n_cancel += exp_q.size();
      exp_q.delete();
      step();
      flush = 1'b0;
   endtask

   task automatic test_done(input string name);
      $display("test %s finished, %0d errors", name, errors - test_errs);
      test_errs = errors;
   endtask

   // response side: drives rsp_ready, pops one expected value per transfer
   initial begin : compare
      hilo_t exp;
      rsp_ready = 1'b1;
      forever begin
         step();
         rsp_ready = rnd_ready ? rdy_pat[cyc % 1024] : 1'b1;
         @(negedge aclk);
         if (rsp_valid && rsp_ready) begin
            n_rcvd++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("ERROR: response %h at %0t ns with no request outstanding", rsp, $time);
            end else begin
               exp = exp_q.pop_front();
               check_val(rsp, exp, "response");
            end
         end
      end
   end

   initial begin : watchdog
      #(2 * (n_random + n_directed) * 40 * clk_period);
      $display("ERROR: run timed out at %0t ns before all tests finished", $time);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] a;
      logic [31:0] b;
      int          ic;
      int          at;
      rst       = 1'b0;
      flush     = 1'b0;
      req_valid = 1'b0;
      req       = '0;

      repeat (9) @(posedge aclk);
      @(negedge aclk);
      check_val(req_ready, 0, "req_ready in reset");
      check_val(rsp_valid, 0, "rsp_valid in reset");
      step();
      rst = 1'b1;
      @(negedge aclk);
      check_val(req_ready, 0, "req_ready right after reset");
      check_val(rsp_valid, 0, "rsp_valid right after reset");
      step();
      send_req(OP_MULT, 32'hffff_fff9, 32'd6, ic);
      drain();
      test_done("reset");

      for (int i = 0; i < 5; i++) begin
         send_req(OP_MULT, mul_a[i], mul_b[i], ic);
         send_req(OP_MULTU, mul_a[i], mul_b[i], ic);
      end
      drain();
      test_done("directed multiply");

      for (int i = 0; i < 8; i++) begin
         send_req(OP_DIV, div_a[i], div_b[i], ic);
         send_req(OP_DIVU, div_a[i], div_b[i], ic);
      end
      drain();
      test_done("directed divide");

      for (int i = 0; i < 1024; i++) begin
         r = $random(seed);
         rdy_pat[i] = (r[7:0] % 3) != 0;   // low about one cycle in three
      end
      rnd_ready = 1'b1;
      for (int i = 0; i < n_random; i++) begin
         r = $random(seed);
         a = $random(seed);
         b = $random(seed);
         if (r[4:2] == 3'd0) begin
            b = '0;
         end
         if (r[4:2] == 3'd1) begin
            a = 32'h8000_0000;
         end
         send_req(muldiv_op_e'(r[1:0]), a, b, ic);
      end
      drain();
      rnd_ready = 1'b0;
      test_done("random stream");

      send_req(OP_MULTU, 32'd3, 32'd5, ic);
      wait_rsp(at);
      check_val(at - ic, 3, "multiply latency");
      drain();
      send_req(OP_DIV, 32'd1000, 32'hffff_fff9, ic);
      wait_rsp(at);
      check_val(at - ic, 35, "divide latency");
      drain();
      test_done("latency");

      send_req(OP_DIV, 32'd1000, 32'd7, ic);
      repeat (16) step();                  // divider halfway through
      cancel_all();
      repeat (40) step();
      send_req(OP_DIVU, 32'hffff_0000, 32'd9, ic);
      drain();
      send_req(OP_MULT, 32'h0001_0001, 32'hffff_fffd, ic);
      send_req(OP_MULTU, 32'hffff_ffff, 32'd2, ic);
      cancel_all();                        // both still in the pipeline
      repeat (10) step();
      send_req(OP_MULT, 32'h8000_0000, 32'd3, ic);
      drain();
      test_done("flush");

      errors += u_dut.u_seq.u_assert.fail_cnt;
      check_val(n_rcvd, n_sent - n_cancel, "response count");
      $display("summary: %0d checks, %0d errors, %0d requests, %0d responses",
               checks, errors, n_sent, n_rcvd);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
source/muldiv_pkg.sv
source/mul_unit.sv
source/div_unit.sv
source/muldiv_seq.sv
source/muldiv_top.sv
verif/muldiv_assert.sv
verif/muldiv_tb.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  - source/muldiv_pkg.sv
  - source/mul_unit.sv
  - source/div_unit.sv
  - source/muldiv_seq.sv
  - source/muldiv_top.sv
  - target: simulation
    files:
      - verif/muldiv_assert.sv
      - verif/muldiv_tb.sv
